//--- all.f
src/tx_pkg.sv
src/rq_ctrl.sv
src/rq_header_builder.sv
src/cc_completer.sv
src/latency_logger.sv
src/tx_engine.sv
sim/tb_tx_engine_asserts.sv
sim/tb_tx_engine.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the tx engine testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_tx_engine -f all.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "verilator compile failed with status $status"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" sim.log; then
   exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
   echo "no pass line in sim.log"
   exit 1
fi
exit 0

//--- sim/tb_tx_engine.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// table-driven testbench, random ready stalls and fifo words
// fill rows run 8192 bursts each, so the run takes tens of thousands of cycles
//----------------------------------------------------------------------
module tb_tx_engine;
   import tx_pkg::*;

   typedef enum {K_CC, K_WR, K_FILL_HOLD, K_FILL_CONT, K_INIT, K_LATRST} row_kind_e;
   localparam int NROWS = 15;

   logic clk = 1'b0;
   logic rst_n, init_rst_i, latency_reset_i, start_i, resume_i, log_continue_i;
   wr_cfg_t    wr_cfg_i;
   cc_req_t    cc_req_i;
   logic       req_compl_i;
   dword_t     rd_data_i;
   beat_t      fifo_data_i;
   logic       rq_ready_i, cc_ready_i;
   axis_beat_t rq_beat_o, cc_beat_o;
   logic       rq_valid_o, cc_valid_o, fifo_read_en_o, compl_done_o, log_we_o, stop_o;
   keep_t      rq_tuser_o;
   log_addr_t  log_addr_o;
   stamp_t     log_data_o, timestamp_o;

   // stimulus table
   string     row_name [NROWS];
   row_kind_e row_kind [NROWS];
   wr_cfg_t   row_cfg  [NROWS];
   be_t       row_be   [NROWS];

   // models and scoreboard state
   logic [31:0] rng = 32'd6948;
   string       cur_name;          // row being run
   beat_t       pay_q[$];          // words popped, not yet sent
   int          in_pay;            // payload beats owed, 0 means header next
   int          hdr_cnt, log_cnt, cc_cnt, done_cnt, err_cnt;
   logic        at_max_seen, have_prev;
   tag_t        exp_tag;
   log_addr_t   exp_addr;
   stamp_t      ts_model, ts_d1, prev_data;
   axis_beat_t  cc_seen;

   tx_engine DUT (.*);

   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic rand_beat(output beat_t b);
      for (int i = 0; i < 8; i++) begin
         rng = xorshift(rng);
         b[i*32 +: 32] = rng;
      end
   endtask

   // ------------------------------------------------------------------
   // expected descriptors, field by field
   // ------------------------------------------------------------------
   function automatic beat_t exp_header(input wr_cfg_t c, input tag_t t);
      beat_t h;
      h = '0;
      h[31:2]   = c.addr[31:2];      // 32-bit address, type 0
      h[74:64]  = {1'b0, c.len};     // dword count
      h[78:75]  = 4'b0001;           // memory write
      h[103:96] = t;
      return h;
   endfunction

   function automatic axis_beat_t exp_compl(input cc_req_t r, input dword_t d);
      axis_beat_t b;
      int lo;
      int hi;
      b = '0;
      lo = -1;
      hi = -1;
      for (int i = 0; i < 4; i++) begin
         if (r.be[i]) begin
            if (lo < 0) lo = i;
            hi = i;
         end
      end
      b.data[28:16] = (lo < 0) ? 13'd1 : byte_cnt_t'(hi - lo + 1);
      b.data[6:0]   = {r.addr[4:0], (lo < 0) ? 2'd0 : lo[1:0]};
      b.data[42:32] = {1'b0, r.len};
      b.data[63:48] = r.rid;
      b.data[71:64] = r.tag;
      b.data[91:89] = r.tc;
      b.data[93:92] = r.attr;
      b.data[127:96] = d;            // read data in dword 3
      b.keep = 8'h0F;
      b.last = 1'b1;
      return b;
   endfunction

   // ------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------
   task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
      if (exp !== act) begin
         $display("[ERROR] %s %s: expected %h, actual %h", cur_name, name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_tuser(input string name, input keep_t exp, input keep_t act);
      if (exp !== act) begin
         $display("[ERROR] %s %s: expected %h, actual %h", cur_name, name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_addr(input string name, input log_addr_t exp, input log_addr_t act);
      if (exp !== act) begin
         $display("[ERROR] %s %s: expected %h, actual %h", cur_name, name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_stamp(input string name, input stamp_t exp, input stamp_t act);
      if (exp !== act) begin
         $display("[ERROR] %s %s: expected %h, actual %h", cur_name, name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("%s", msg);
      err_cnt++;
   endtask

   task automatic abort_on_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("Test failed");
      $finish;
   endtask

   // ------------------------------------------------------------------
   // one clock: sample at negedge, drive 1 ns after posedge
   // ------------------------------------------------------------------
   task automatic step;
      beat_t      nb;
      axis_beat_t eb;
      logic       popped;
      @(negedge clk);
      popped = 1'b0;
      if (fifo_read_en_o) begin        // fifo model pops its word
         pay_q.push_back(fifo_data_i);
         popped = 1'b1;
      end
      if (rq_valid_o && rq_ready_i) begin
         if (in_pay == 0) begin
            eb.data = exp_header(wr_cfg_i, exp_tag);
            eb.keep = 8'hFF;
            eb.last = 1'b0;
            check_beat("rq header", eb, rq_beat_o);
            check_tuser("rq tuser", {wr_cfg_i.lbe, wr_cfg_i.fbe}, rq_tuser_o);
            exp_tag = exp_tag + 8'd2;
            in_pay  = int'(wr_cfg_i.len) / 8;
            hdr_cnt++;
         end else begin
            if (pay_q.size() == 0) begin
               note_failure("payload beat sent without a fifo read");
            end else begin
               eb.data = pay_q.pop_front();
               eb.keep = 8'hFF;
               eb.last = (in_pay == 1);
               check_beat("rq payload", eb, rq_beat_o);
            end
            in_pay--;
         end
      end
      if (cc_valid_o && cc_ready_i) begin
         cc_cnt++;
         cc_seen = cc_beat_o;
      end
      if (compl_done_o) done_cnt++;
      if (log_we_o) begin
         check_addr("log addr", exp_addr, log_addr_o);
         check_stamp("log data", ts_d1, log_data_o);
         if (have_prev && log_data_o <= prev_data) note_failure("log timestamp did not grow");
         prev_data = log_data_o;
         have_prev = 1'b1;
         log_cnt++;
         if (exp_addr == LOG_ADDR_MAX) begin
            at_max_seen = 1'b1;
            if (log_continue_i) exp_addr = '0;
         end else begin
            exp_addr = exp_addr + 13'd1;
         end
      end
      check_stamp("timestamp", ts_model, timestamp_o);
      ts_d1 = ts_model;                // stamp seen by the next write edge
      @(posedge clk);
      if (!rst_n || latency_reset_i) ts_model = '0;
      else if (start_i) ts_model = ts_model + stamp_t'(1);
      #1;
      if (popped) begin
         rand_beat(nb);
         fifo_data_i = nb;
      end
      rng = xorshift(rng);
      rq_ready_i = (rng[1:0] != 2'b00);   // stall about one cycle in four
      cc_ready_i = (rng[9:8] != 2'b00);
   endtask

   // ------------------------------------------------------------------
   // row handlers
   // ------------------------------------------------------------------
   task automatic run_cc(input int r);
      int n;
      rng = xorshift(rng);
      cc_req_i = '{tc: rng[2:0], attr: rng[4:3], len: 10'd1, rid: rng[31:16],
                   tag: rng[12:5], be: row_be[r], addr: {rng[15:13], rng[7:0]}};
      rng = xorshift(rng);
      rd_data_i = rng;
      cc_cnt = 0;
      done_cnt = 0;
      req_compl_i = 1'b1;
      step;
      req_compl_i = 1'b0;
      n = 0;
      while (cc_cnt == 0) begin
         step;
         n++;
         if (n > 100) abort_on_timeout("completion beat");
      end
      repeat (4) step;                 // catch a second pulse
      check_beat("completion", exp_compl(cc_req_i, rd_data_i), cc_seen);
      if (done_cnt != 1) note_failure("compl_done_o did not pulse exactly once");
      if (cc_cnt != 1) note_failure("more than one completion beat");
   endtask

   task automatic run_wr(input int r);
      int n;
      int h0;
      int l0;
      h0 = hdr_cnt;
      l0 = log_cnt;
      wr_cfg_i = row_cfg[r];
      start_i = 1'b1;
      n = 0;
      while (!rq_valid_o) begin
         step;
         n++;
         if (n > 100) abort_on_timeout("burst header");
      end
      start_i = 1'b0;
      n = 0;
      while (log_cnt == l0 || in_pay != 0) begin
         step;
         n++;
         if (n > 500) abort_on_timeout("burst end and log write");
      end
      repeat (3) step;
      if (hdr_cnt != h0 + 1) note_failure("wrong number of headers in the burst");
      if (log_cnt != l0 + 1) note_failure("wrong number of log writes for one burst");
   endtask

   task automatic run_fill(input int r, input logic cont);
      int n;
      int h0;
      int l0;
      log_continue_i = cont;
      wr_cfg_i = row_cfg[r];
      at_max_seen = 1'b0;
      start_i = 1'b1;
      n = 0;
      while (!at_max_seen) begin
         step;
         n++;
         if (n > 100000) abort_on_timeout("log write at the last address");
      end
      step;
      check_addr("addr after last write", cont ? 13'd0 : LOG_ADDR_MAX, log_addr_o);
      if (!stop_o) note_failure("stop_o low after the last log address");
      if (cont) start_i = 1'b0;
      n = 0;
      while (rq_valid_o || in_pay != 0) begin
         step;
         n++;
         if (n > 200) abort_on_timeout("stream idle after stop");
      end
      h0 = hdr_cnt;
      l0 = log_cnt;
      repeat (30) step;
      if (!cont) begin
         if (hdr_cnt != h0) note_failure("header started while stop_o was high");
         if (!stop_o) note_failure("stop_o dropped in hold mode");
         check_addr("hold addr", LOG_ADDR_MAX, log_addr_o);
         start_i = 1'b0;
      end else begin
         resume_i = 1'b1;
         step;
         resume_i = 1'b0;
         step;
         if (stop_o) note_failure("stop_o still high after resume_i");
      end
   endtask

   task automatic set_row(input int i, input string nm, input row_kind_e k,
                          input wr_cfg_t c, input be_t be);
      row_name[i] = nm;
      row_kind[i] = k;
      row_cfg[i]  = c;
      row_be[i]   = be;
   endtask

   initial begin
      int   pass_rows;
      int   fail_rows;
      int   e0;
      logic s0;
      set_row(0,  "cc_be_full",   K_CC, '0, 4'b1111);
      set_row(1,  "cc_be_span3",  K_CC, '0, 4'b0111);
      set_row(2,  "cc_be_mid2",   K_CC, '0, 4'b0110);
      set_row(3,  "cc_be_gap",    K_CC, '0, 4'b1010);
      set_row(4,  "cc_be_single", K_CC, '0, 4'b0100);
      set_row(5,  "cc_be_none",   K_CC, '0, 4'b0000);
      set_row(6,  "wr_len8",   K_WR, wr_cfg_t'{10'd8,  4'hF, 4'hF, 32'h0000_1000}, '0);
      set_row(7,  "wr_len32",  K_WR, wr_cfg_t'{10'd32, 4'hE, 4'h3, 32'h1234_5678}, '0);
      set_row(8,  "wr_len64",  K_WR, wr_cfg_t'{10'd64, 4'hF, 4'h1, 32'hFFFF_FFFC}, '0);
      set_row(9,  "fill_hold", K_FILL_HOLD, wr_cfg_t'{10'd8, 4'hF, 4'hF, 32'h2000}, '0);
      set_row(10, "init_rst",  K_INIT, '0, '0);
      set_row(11, "lat_reset", K_LATRST, '0, '0);
      set_row(12, "wr_after_init", K_WR, wr_cfg_t'{10'd16, 4'h1, 4'h8, 32'hA5A5_0004}, '0);
      set_row(13, "fill_cont", K_FILL_CONT, wr_cfg_t'{10'd8, 4'hF, 4'hF, 32'h3000}, '0);
      set_row(14, "wr_after_wrap", K_WR, wr_cfg_t'{10'd8, 4'h7, 4'hC, 32'h0000_0040}, '0);

      rst_n = 1'b0;
      init_rst_i = 1'b0;
      latency_reset_i = 1'b0;
      start_i = 1'b0;
      resume_i = 1'b0;
      log_continue_i = 1'b0;
      wr_cfg_i = '0;
      cc_req_i = '0;
      req_compl_i = 1'b0;
      rd_data_i = '0;
      rand_beat(fifo_data_i);
      rq_ready_i = 1'b1;
      cc_ready_i = 1'b1;
      in_pay = 0;
      cur_name = "reset";
      {hdr_cnt, log_cnt, cc_cnt, done_cnt, err_cnt} = '0;
      {at_max_seen, have_prev} = 2'b00;
      exp_tag = 8'd1;
      exp_addr = '0;
      {ts_model, ts_d1, prev_data} = '0;
      pass_rows = 0;
      fail_rows = 0;

      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;
      if (rq_valid_o || cc_valid_o || compl_done_o || fifo_read_en_o || log_we_o || stop_o)
         note_failure("control outputs not low after reset");

      for (int r = 0; r < NROWS; r++) begin
         e0 = err_cnt;
         cur_name = row_name[r];
         case (row_kind[r])
            K_CC:        run_cc(r);
            K_WR:        run_wr(r);
            K_FILL_HOLD: run_fill(r, 1'b0);
            K_FILL_CONT: run_fill(r, 1'b1);
            K_INIT: begin
               s0 = stop_o;
               init_rst_i = 1'b1;
               step;
               init_rst_i = 1'b0;
               if (rq_valid_o || cc_valid_o || compl_done_o || fifo_read_en_o || log_we_o)
                  note_failure("control outputs not low after init_rst_i");
               if (stop_o !== s0) note_failure("init_rst_i changed stop_o");
               exp_tag = 8'd1;   // tag counter restarts
               in_pay = 0;
            end
            default: begin
               latency_reset_i = 1'b1;
               step;
               latency_reset_i = 1'b0;
               exp_addr = '0;
               have_prev = 1'b0;
               check_addr("log addr", '0, log_addr_o);
               check_stamp("timestamp", '0, timestamp_o);
               if (stop_o) note_failure("stop_o high after latency_reset_i");
            end
         endcase
         if (err_cnt == e0) begin
            pass_rows++;
            $display("row %0d %s: ok", r, row_name[r]);
         end else begin
            fail_rows++;
            $display("row %0d %s: FAILED with %0d errors", r, row_name[r], err_cnt - e0);
         end
      end

      $display("rows passed %0d, rows failed %0d, errors %0d", pass_rows, fail_rows, err_cnt);
      if (err_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- sim/tb_tx_engine_asserts.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// stream and log protocol properties, bound into tx_engine
// init_rst_i is only pulsed while both streams are idle
//----------------------------------------------------------------------
module tb_tx_engine_asserts (
   input logic               clk,
   input logic               rst_n,
   input logic               init_rst_i,
   input logic               rq_valid_o,
   input logic               rq_ready_i,
   input tx_pkg::axis_beat_t rq_beat_o,
   input logic               cc_valid_o,
   input logic               cc_ready_i,
   input tx_pkg::axis_beat_t cc_beat_o,
   input logic               fifo_read_en_o,
   input logic               log_we_o
);
   // stalled beats hold
   rq_hold: assert property (@(posedge clk) disable iff (!rst_n || init_rst_i)
      rq_valid_o && !rq_ready_i |=> rq_valid_o && $stable(rq_beat_o))
      else $error("rq beat changed during stall");

   cc_hold: assert property (@(posedge clk) disable iff (!rst_n || init_rst_i)
      cc_valid_o && !cc_ready_i |=> cc_valid_o && $stable(cc_beat_o))
      else $error("cc beat changed during stall");

   // reads only while a non-last beat leaves
   fifo_rd_ready: assert property (@(posedge clk) disable iff (!rst_n)
      fifo_read_en_o |-> rq_ready_i && rq_valid_o && !rq_beat_o.last)
      else $error("fifo read outside a payload transfer");

   log_we_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      log_we_o |=> !log_we_o)
      else $error("log write longer than one cycle");

endmodule

bind tx_engine tb_tx_engine_asserts u_asserts (
   .clk            (clk),
   .rst_n          (rst_n),
   .init_rst_i     (init_rst_i),
   .rq_valid_o     (rq_valid_o),
   .rq_ready_i     (rq_ready_i),
   .rq_beat_o      (rq_beat_o),
   .cc_valid_o     (cc_valid_o),
   .cc_ready_i     (cc_ready_i),
   .cc_beat_o      (cc_beat_o),
   .fifo_read_en_o (fifo_read_en_o),
   .log_we_o       (log_we_o)
);

//--- src/cc_completer.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// one-beat completion with data for a pio read
// cc_req_i and rd_data_i are sampled when the completion is loaded
//----------------------------------------------------------------------
module cc_completer (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               init_rst_i,
   input  logic               req_compl_i,
   input  tx_pkg::cc_req_t    cc_req_i,
   input  tx_pkg::dword_t     rd_data_i,
   input  logic               cc_ready_i,
   output tx_pkg::axis_beat_t cc_beat_o,
   output logic               cc_valid_o,
   output logic               compl_done_o
);
   import tx_pkg::*;

   logic       req_compl_q;
   byte_cnt_t  byte_cnt;
   logic [1:0] be_idx;       // lowest enabled byte
   logic [6:0] lower_addr;
   beat_t      desc;

   // ------------------------------------------------------------------
   // byte count and lower address from the byte enables
   // ------------------------------------------------------------------
   always_comb begin
      casez (cc_req_i.be)
         4'b1??1:                   byte_cnt = 13'd4;
         4'b01?1, 4'b1?10:          byte_cnt = 13'd3;
         4'b0011, 4'b0110, 4'b1100: byte_cnt = 13'd2;
         default:                   byte_cnt = 13'd1;   // single or none
      endcase
   end

   always_comb begin
      casez (cc_req_i.be)
         4'b???1: be_idx = 2'd0;
         4'b??10: be_idx = 2'd1;
         4'b?100: be_idx = 2'd2;
         4'b1000: be_idx = 2'd3;
         default: be_idx = 2'd0;   // no enable
      endcase
   end

   assign lower_addr = {cc_req_i.addr[4:0], be_idx};

   assign desc = {
      128'd0,
      rd_data_i,               // dword 3
      1'b0,                    // force ecrc
      1'b0, cc_req_i.attr,
      cc_req_i.tc,
      1'b0,                    // completer id enable
      16'd0,                   // completer id
      cc_req_i.tag,
      cc_req_i.rid,
      1'b0,                    // reserved
      1'b0,                    // poisoned
      3'b000,                  // successful completion
      {1'b0, cc_req_i.len},    // dword count
      2'b00,
      1'b0,                    // locked read
      byte_cnt,
      6'd0,
      2'b00,                   // address type
      1'b0,
      lower_addr
   };

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_compl_q <= 1'b0;
      end else begin
         req_compl_q <= req_compl_i;
      end
   end

   // ------------------------------------------------------------------
   // load and hold until the core takes it
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n || init_rst_i) begin
         cc_beat_o    <= '0;
         cc_valid_o   <= 1'b0;
         compl_done_o <= 1'b0;
      end else begin
         compl_done_o <= 1'b0;   // one cycle only
         if (!cc_valid_o) begin
            if (req_compl_q) begin
               cc_beat_o.data <= desc;
               cc_beat_o.keep <= CC_KEEP;
               cc_beat_o.last <= 1'b1;
               cc_valid_o     <= 1'b1;
               compl_done_o   <= 1'b1;
            end
         end else if (cc_ready_i) begin
            cc_valid_o     <= 1'b0;   // taken this edge
            cc_beat_o.last <= 1'b0;
         end
      end
   end

endmodule

//--- src/latency_logger.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// 40-bit timestamp and burst-end log writes into an 8k-entry memory
// hold mode keeps stop high until latency_reset_i
//----------------------------------------------------------------------
module latency_logger (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              latency_reset_i,
   input  logic              start_i,
   input  logic              resume_i,
   input  logic              log_continue_i,
   input  logic              burst_done_i,
   output logic              log_we_o,
   output tx_pkg::log_addr_t log_addr_o,
   output tx_pkg::stamp_t    log_data_o,
   output tx_pkg::stamp_t    timestamp_o,
   output logic              stop_o
);
   import tx_pkg::*;

   logic hold_full;   // hold mode with the log used up

   assign hold_full = !log_continue_i && stop_o;

   always_ff @(posedge clk) begin
      if (!rst_n || latency_reset_i) begin
         timestamp_o <= '0;
         log_addr_o  <= '0;
         log_we_o    <= 1'b0;
         stop_o      <= 1'b0;
      end else begin
         if (start_i) begin
            timestamp_o <= timestamp_o + stamp_t'(1);   // counts while sending
         end

         log_we_o <= burst_done_i && !hold_full;   // no writes past the end

         if (log_we_o && (log_addr_o == LOG_ADDR_MAX)) begin
            stop_o <= 1'b1;
            if (log_continue_i) begin
               log_addr_o <= '0;   // wrap
            end
         end else begin
            if (log_we_o) begin
               log_addr_o <= log_addr_o + log_addr_t'(1);
            end
            if (resume_i && log_continue_i) begin
               stop_o <= 1'b0;
            end
         end
      end
   end

   // stamp at the write edge
   always_ff @(posedge clk) begin
      if (burst_done_i) begin
         log_data_o <= timestamp_o;
      end
   end

endmodule

//--- src/rq_ctrl.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// write burst control, one header beat then len/8 payload beats
// fifo is first-word-fall-through, next word shows the cycle after a read
//----------------------------------------------------------------------
module rq_ctrl (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               init_rst_i,
   input  logic               start_i,
   input  logic               stop_i,         // log full, no new header
   input  logic               rq_ready_i,
   input  tx_pkg::wr_cfg_t    wr_cfg_i,
   input  tx_pkg::beat_t      hdr_beat_i,
   input  tx_pkg::beat_t      fifo_data_i,
   output logic               hdr_take_o,
   output tx_pkg::axis_beat_t rq_beat_o,
   output logic               rq_valid_o,
   output logic               fifo_read_en_o,
   output logic               burst_done_o
);
   import tx_pkg::*;

   rq_state_e state;
   dw_len_t   dw_left;    // dwords still owed to the stream
   logic      hdr_go;     // header loads at this edge

   // header only from idle, only when the stream takes a beat
   assign hdr_go = (state == RQ_IDLE) && start_i && rq_ready_i && !stop_i;

   assign hdr_take_o = hdr_go;   // tag counter steps with the load

   // every read lines up with a payload load below
   assign fifo_read_en_o = (state == RQ_PAYLOAD) && rq_ready_i;

   // ------------------------------------------------------------------
   // burst state machine
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n || init_rst_i) begin
         state        <= RQ_IDLE;
         dw_left      <= '0;
         rq_valid_o   <= 1'b0;
         rq_beat_o    <= '0;
         burst_done_o <= 1'b0;
      end else begin
         burst_done_o <= 1'b0;   // strobe

         case (state)
            RQ_IDLE: begin
               if (hdr_go) begin
                  rq_beat_o.data <= hdr_beat_i;
                  rq_beat_o.keep <= RQ_KEEP;
                  rq_beat_o.last <= 1'b0;
                  rq_valid_o     <= 1'b1;
                  dw_left        <= wr_cfg_i.len;
                  state          <= RQ_PAYLOAD;
               end else if (rq_ready_i) begin
                  // last beat gone, stream goes quiet
                  rq_valid_o <= 1'b0;
                  rq_beat_o  <= '0;
               end
               // ready low, last beat of the burst holds
            end

            RQ_PAYLOAD: begin
               if (rq_ready_i) begin
                  rq_beat_o.data <= fifo_data_i;   // word shown before the pop
                  rq_beat_o.keep <= RQ_KEEP;
                  dw_left        <= dw_left - BEAT_DW;

                  // one beat left, this is it
                  if (dw_left == BEAT_DW) begin
                     rq_beat_o.last <= 1'b1;
                     burst_done_o   <= 1'b1;
                     state          <= RQ_IDLE;
                  end
               end
               // stall: beat, valid and counter hold
            end

            default: begin
               state <= RQ_IDLE;
            end
         endcase
      end
   end

endmodule

//--- src/rq_header_builder.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// memory write header for the requester stream, 32-bit address only
// tags are odd, 1 for the first burst, wrapping after 128 bursts
//----------------------------------------------------------------------
module rq_header_builder (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            init_rst_i,
   input  logic            hdr_take_i,    // header loaded by the control
   input  tx_pkg::wr_cfg_t wr_cfg_i,
   output tx_pkg::beat_t   hdr_beat_o,
   output tx_pkg::keep_t   hdr_tuser_o
);
   import tx_pkg::*;

   logic [6:0] burst_cnt;   // bursts sent, wraps
   tag_t       tag;

   assign tag = {burst_cnt, 1'b1};   // low bit fixed

   always_ff @(posedge clk) begin
      if (!rst_n || init_rst_i) begin
         burst_cnt <= '0;
      end else if (hdr_take_i) begin
         burst_cnt <= burst_cnt + 7'd1;
      end
   end

   // ------------------------------------------------------------------
   // descriptor, lower four dwords only
   // ------------------------------------------------------------------
   assign hdr_beat_o = {
      128'd0,                  // upper dwords unused
      1'b0,                    // force ecrc
      3'd0,                    // attr
      3'd0,                    // tc
      1'b0,                    // requester id enable
      16'd0,                   // completer id
      tag,
      16'd0,                   // requester id, core fills it
      1'b0,                    // poisoned
      REQ_MEM_WR,
      {1'b0, wr_cfg_i.len},    // dword count
      32'd0,                   // address 63..32
      wr_cfg_i.addr[31:2],
      2'b00                    // address type
   };

   assign hdr_tuser_o = {wr_cfg_i.lbe, wr_cfg_i.fbe};

endmodule

//--- src/tx_engine.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// pcie tx engine top, requester write bursts, pio completions and log
// wr_cfg_i and cc_req_i must stay stable while they are in use
//----------------------------------------------------------------------
module tx_engine (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               init_rst_i,       // initiator reset
   input  logic               latency_reset_i,  // clears stamp, log address, stop
   input  logic               start_i,          // start level for bursts
   input  logic               resume_i,
   input  logic               log_continue_i,   // 1: wrap the log, 0: hold at end
   input  tx_pkg::wr_cfg_t    wr_cfg_i,
   input  tx_pkg::cc_req_t    cc_req_i,
   input  logic               req_compl_i,
   input  tx_pkg::dword_t     rd_data_i,
   input  tx_pkg::beat_t      fifo_data_i,
   input  logic               rq_ready_i,
   input  logic               cc_ready_i,
   output tx_pkg::axis_beat_t rq_beat_o,
   output tx_pkg::axis_beat_t cc_beat_o,
   output logic               rq_valid_o,
   output logic               cc_valid_o,
   output tx_pkg::keep_t      rq_tuser_o,       // {last be, first be}
   output logic               fifo_read_en_o,
   output logic               compl_done_o,
   output logic               log_we_o,
   output tx_pkg::log_addr_t  log_addr_o,
   output tx_pkg::stamp_t     log_data_o,
   output tx_pkg::stamp_t     timestamp_o,
   output logic               stop_o
);
   import tx_pkg::*;

   beat_t hdr_beat;      // header built for the next burst
   keep_t hdr_tuser;
   logic  hdr_take;      // header loaded this edge
   logic  burst_done;    // tlast presented
   logic  stop;

   // ------------------------------------------------------------------
   // requester request side
   // ------------------------------------------------------------------
   rq_ctrl u_rq_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .init_rst_i     (init_rst_i),
      .start_i        (start_i),
      .stop_i         (stop),
      .rq_ready_i     (rq_ready_i),
      .wr_cfg_i       (wr_cfg_i),
      .hdr_beat_i     (hdr_beat),
      .fifo_data_i    (fifo_data_i),
      .hdr_take_o     (hdr_take),
      .rq_beat_o      (rq_beat_o),
      .rq_valid_o     (rq_valid_o),
      .fifo_read_en_o (fifo_read_en_o),
      .burst_done_o   (burst_done)
   );

   rq_header_builder u_rq_header_builder (
      .clk         (clk),
      .rst_n       (rst_n),
      .init_rst_i  (init_rst_i),
      .hdr_take_i  (hdr_take),
      .wr_cfg_i    (wr_cfg_i),
      .hdr_beat_o  (hdr_beat),
      .hdr_tuser_o (hdr_tuser)
   );

   assign rq_tuser_o = hdr_tuser;   // be fields straight from the config

   // ------------------------------------------------------------------
   // completer completion side
   // ------------------------------------------------------------------
   cc_completer u_cc_completer (
      .clk          (clk),
      .rst_n        (rst_n),
      .init_rst_i   (init_rst_i),
      .req_compl_i  (req_compl_i),
      .cc_req_i     (cc_req_i),
      .rd_data_i    (rd_data_i),
      .cc_ready_i   (cc_ready_i),
      .cc_beat_o    (cc_beat_o),
      .cc_valid_o   (cc_valid_o),
      .compl_done_o (compl_done_o)
   );

   // no init_rst_i here, stop survives an initiator reset
   latency_logger u_latency_logger (
      .clk             (clk),
      .rst_n           (rst_n),
      .latency_reset_i (latency_reset_i),
      .start_i         (start_i),
      .resume_i        (resume_i),
      .log_continue_i  (log_continue_i),
      .burst_done_i    (burst_done),
      .log_we_o        (log_we_o),
      .log_addr_o      (log_addr_o),
      .log_data_o      (log_data_o),
      .timestamp_o     (timestamp_o),
      .stop_o          (stop)
   );

   assign stop_o = stop;

endmodule

//--- src/tx_pkg.sv
//----------------------------------------------------------------------
// shared types and constants of the tx engine
// burst lengths are whole multiples of eight dwords
//----------------------------------------------------------------------
package tx_pkg;

   // ------------------------------------------------------------------
   // widths with a meaning
   // ------------------------------------------------------------------
   typedef logic [31:0]  dword_t;      // one data word
   typedef logic [255:0] beat_t;       // eight dwords
   typedef logic [7:0]   keep_t;       // one bit per dword
   typedef logic [3:0]   be_t;         // byte enables of a dword
   typedef logic [7:0]   tag_t;
   typedef logic [9:0]   dw_len_t;     // burst length in dwords
   typedef logic [12:0]  byte_cnt_t;
   typedef logic [39:0]  stamp_t;
   typedef logic [12:0]  log_addr_t;

   // pio read to answer, from the receive side
   typedef struct packed {
      logic [2:0]  tc;
      logic [1:0]  attr;
      dw_len_t     len;
      logic [15:0] rid;                // requester id
      tag_t        tag;
      be_t         be;
      logic [10:0] addr;               // dword address
   } cc_req_t;

   // write burst settings, static while a burst runs
   typedef struct packed {
      dw_len_t len;
      be_t     fbe;
      be_t     lbe;
      dword_t  addr;                   // target address
   } wr_cfg_t;

   typedef struct packed {
      beat_t data;
      keep_t keep;
      logic  last;
   } axis_beat_t;

   typedef enum logic {RQ_IDLE, RQ_PAYLOAD} rq_state_e;

   localparam dw_len_t    BEAT_DW      = 10'd8;
   localparam log_addr_t  LOG_ADDR_MAX = 13'd8191;
   localparam keep_t      CC_KEEP      = 8'h0F;     // 3dw descriptor + 1 data dword
   localparam keep_t      RQ_KEEP      = 8'hFF;
   localparam logic [3:0] REQ_MEM_WR   = 4'b0001;

endpackage
